// File: common/obj_pkg.sv
// object layer constants
`default_nettype none

package obj_pkg;

    // attribute table geometry
    localparam int OBJ_COUNT      = 64;
    localparam int OBJ_BYTES      = 5;                        // bytes per entry
    localparam int OBJ_TABLE_SIZE = OBJ_COUNT * OBJ_BYTES;    // 320 bytes
    localparam int OBJ_TABLE_AW   = 9;
    localparam int OBJ_TABLE_LAST = (OBJ_COUNT - 1) * OBJ_BYTES;  // base of final entry

    // byte offsets inside one entry
    localparam logic [2:0] ATTR_CODE  = 3'd0;   // code bits 9:2
    localparam logic [2:0] ATTR_COLOR = 3'd1;   // palette and code bits 11:10
    localparam logic [2:0] ATTR_Y     = 3'd2;
    localparam logic [2:0] ATTR_X     = 3'd3;   // low x bits
    localparam logic [2:0] ATTR_SIZE  = 3'd4;   // size, flips, x msb, code msbs

    // bit positions in the size byte
    localparam int SIZE_X8_BIT    = 0;
    localparam int SIZE_BIG_BIT   = 1;          // set for 16 px objects
    localparam int SIZE_HFLIP_BIT = 4;
    localparam int SIZE_VFLIP_BIT = 5;

    localparam logic [7:0] OBJ_END_Y        = 8'd240;   // y value that ends the list
    localparam logic [8:0] OBJ_PIXEL_BUDGET = 9'd384;   // pixels drawn per line
    localparam logic [8:0] OBJ_X_OFFSET     = 9'd0;     // aligns object x with hdump

    // tile ROM address is code, row, half-row
    localparam int OBJ_ROM_AW = 18;

endpackage

`default_nettype wire

// File: obj_engine/obj_drawer.sv
// object line drawer
`default_nettype none

module obj_drawer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              LHBL,
    input  logic                              LVBL,
    input  logic [8:0]                        vrender,
    output logic [obj_pkg::OBJ_TABLE_AW-1:0]  scan_addr,
    input  logic [7:0]                        obj_scan,
    output logic [7:0]                        lut_index,
    output logic                              lut_valid,
    output logic [8:0]                        xpos,
    output logic                              rom_cs,
    output logic [obj_pkg::OBJ_ROM_AW-1:0]    rom_addr,
    input  logic                              rom_ok,
    input  logic [15:0]                       rom_data,
    output logic                              done
);
    import obj_pkg::*;

    typedef enum logic [3:0] {
        ST_SIZE,
        ST_Y,
        ST_TEST,
        ST_CODE,
        ST_COLOR,
        ST_XPOS,
        ST_WAIT,
        ST_DUMP,
        ST_STEP,
        ST_NEXT
    } state_t;

    state_t                  st;
    logic                    last_lhbl;
    logic                    line_start;
    logic [OBJ_TABLE_AW-1:0] scan_base;
    logic [2:0]              byte_sel;
    logic [13:0]             code;
    logic [3:0]              pal;
    logic [3:0]              row;         // already flipped
    logic [1:0]              hpos;        // quadrant and half-row
    logic [1:0]              wcnt;        // words done in this row
    logic [1:0]              pcnt;        // pixel inside the word
    logic                    big;
    logic                    hflip;
    logic                    vflip;
    logic                    x8;
    logic [15:0]             pix_data;
    logic [8:0]              xcnt;
    logic [8:0]              pxl_cnt;
    logic [8:0]              vdiff;
    logic                    visible;
    logic [3:0]              nibble;
    logic                    last_word;

    assign line_start = LHBL && !last_lhbl && LVBL;
    assign scan_addr  = scan_base + OBJ_TABLE_AW'(byte_sel);

    // 14 bit code, 3 bit row, half-row
    assign rom_addr = {code[13:1], big ? hpos[1] : code[0], row[2:0], hpos[0]};

    // valid in ST_TEST, where obj_scan holds y
    assign vdiff   = vrender - {1'b0, obj_scan};
    assign visible = vdiff < (big ? 9'd16 : 9'd8);

    assign nibble    = hflip ? pix_data[3:0] : pix_data[15:12];
    assign last_word = wcnt == (big ? 2'd3 : 2'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= ST_SIZE;
            done      <= 1'b1;
            rom_cs    <= 1'b0;
            lut_valid <= 1'b0;
            last_lhbl <= 1'b0;
            scan_base <= '0;
            byte_sel  <= ATTR_SIZE;
            pxl_cnt   <= '0;
        end else begin
            last_lhbl <= LHBL;
            lut_valid <= 1'b0;
            if (line_start) begin
                // unfinished work from the last line is dropped here
                done      <= 1'b0;
                rom_cs    <= 1'b0;
                st        <= ST_SIZE;
                scan_base <= '0;
                byte_sel  <= ATTR_SIZE;
                pxl_cnt   <= '0;
            end else if (!done) begin
                case (st)
                    ST_SIZE: begin
                        byte_sel <= ATTR_Y;
                        st       <= ST_Y;
                    end
                    ST_Y: begin                     // size byte
                        x8          <= obj_scan[SIZE_X8_BIT];
                        big         <= obj_scan[SIZE_BIG_BIT];
                        hflip       <= obj_scan[SIZE_HFLIP_BIT];
                        vflip       <= obj_scan[SIZE_VFLIP_BIT];
                        code[13:12] <= obj_scan[7:6];
                        byte_sel    <= ATTR_CODE;
                        st          <= ST_TEST;
                    end
                    ST_TEST: begin                  // y byte
                        if (obj_scan == OBJ_END_Y) begin
                            done <= 1'b1;
                        end else if (visible) begin
                            row      <= vdiff[3:0] ^ {4{vflip}};
                            byte_sel <= ATTR_COLOR;
                            st       <= ST_CODE;
                        end else begin
                            st <= ST_NEXT;
                        end
                    end
                    ST_CODE: begin
                        code[9:2] <= obj_scan;
                        byte_sel  <= ATTR_X;
                        st        <= ST_COLOR;
                    end
                    ST_COLOR: begin
                        code[11:10] <= obj_scan[1:0];
                        pal         <= obj_scan[7:4];
                        // small objects take the low code bits from the colour byte
                        code[1]     <= big ? row[3] : obj_scan[3];
                        code[0]     <= big ? 1'b0 : obj_scan[2];
                        hpos        <= {2{hflip}};  // right side first when flipped
                        wcnt        <= 2'd0;
                        st          <= ST_XPOS;
                    end
                    ST_XPOS: begin
                        xcnt   <= {x8, obj_scan} + OBJ_X_OFFSET;
                        rom_cs <= 1'b1;
                        st     <= ST_WAIT;
                    end
                    ST_WAIT: begin
                        if (rom_ok) begin
                            pix_data <= rom_data;
                            rom_cs   <= 1'b0;
                            pcnt     <= 2'd0;
                            st       <= ST_DUMP;
                        end
                    end
                    ST_DUMP: begin                  // one pixel per cycle
                        lut_valid <= 1'b1;
                        lut_index <= {pal, nibble};
                        xpos      <= xcnt;
                        xcnt      <= xcnt + 9'd1;
                        pxl_cnt   <= pxl_cnt + 9'd1;
                        pix_data  <= hflip ? pix_data >> 4 : pix_data << 4;
                        pcnt      <= pcnt + 2'd1;
                        if (pcnt == 2'd3) begin
                            st <= ST_STEP;
                        end
                    end
                    ST_STEP: begin
                        hpos <= hflip ? hpos - 2'd1 : hpos + 2'd1;
                        wcnt <= wcnt + 2'd1;
                        if (last_word) begin
                            st <= ST_NEXT;
                        end else begin
                            rom_cs <= 1'b1;
                            st     <= ST_WAIT;
                        end
                    end
                    ST_NEXT: begin
                        byte_sel <= ATTR_SIZE;
                        st       <= ST_SIZE;
                        if (scan_base == OBJ_TABLE_AW'(OBJ_TABLE_LAST) ||
                            pxl_cnt >= OBJ_PIXEL_BUDGET) begin
                            done <= 1'b1;
                        end else begin
                            scan_base <= scan_base + OBJ_TABLE_AW'(OBJ_BYTES);
                        end
                    end
                    default: st <= ST_SIZE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: obj_engine/obj_line_buffer.sv
// ping-pong object line buffer
`default_nettype none

module obj_line_buffer #(
    parameter int LUT_DW  = 4,
    parameter int LINE_AW = 9
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               LHBL,
    input  logic               LVBL,
    input  logic               we,
    input  logic [LINE_AW-1:0] wr_addr,
    input  logic [LUT_DW-1:0]  wr_data,
    input  logic               pxl_cen,
    input  logic [8:0]         hdump,
    output logic [LUT_DW-1:0]  pxl
);

    localparam int DEPTH = 2 ** LINE_AW;

    logic [LUT_DW-1:0] mem [0:2*DEPTH-1];   // both banks
    logic              last_lhbl;
    logic              line_start;
    logic              bank;                // bank being drawn
    logic              wr_bank;             // lags bank by one cycle
    logic              rd_bank;
    logic [LINE_AW:0]  wr_ptr;
    logic [LINE_AW:0]  rd_ptr;

    // both banks start out blank
    initial begin
        for (int i = 0; i < 2 * DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign line_start = LHBL && !last_lhbl && LVBL;
    assign rd_bank    = line_start ? bank : ~bank;
    assign wr_ptr     = {wr_bank, wr_addr};
    assign rd_ptr     = {rd_bank, hdump[LINE_AW-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lhbl <= 1'b0;
            bank      <= 1'b0;
            wr_bank   <= 1'b0;
        end else begin
            last_lhbl <= LHBL;
            wr_bank   <= bank;      // lets a pixel still in the LUT land in its own bank
            if (line_start) begin
                bank <= ~bank;
            end
        end
    end

    always @(posedge clk) begin
        // first pixel to reach a location keeps it
        if (we && wr_data != '0 && mem[wr_ptr] == '0) begin
            mem[wr_ptr] <= wr_data;
        end
        if (pxl_cen) begin
            mem[rd_ptr] <= '0;      // erase behind the read
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: obj_gfx_top.f
common/obj_pkg.sv
source/obj_attr_ram.sv
source/obj_color_lut.sv
obj_engine/obj_drawer.sv
obj_engine/obj_line_buffer.sv
source/obj_gfx_top.sv
sim/obj_rom_model.sv
sim/obj_gfx_assertions.sv
sim/obj_gfx_tb.sv

// File: sim/obj_gfx_assertions.sv
// drawer and ROM handshake checks
`default_nettype none

module obj_gfx_assertions (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            line_start,
    input  logic                            rom_cs,
    input  logic                            rom_ok,
    input  logic [obj_pkg::OBJ_ROM_AW-1:0]  rom_addr,
    input  logic                            lut_valid,
    input  logic                            done
);
    timeunit 1ns;
    timeprecision 1ps;

    // address held while the ROM has not answered
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> !rom_cs || $stable(rom_addr))
        else $error("rom_addr moved during a ROM wait");

    // a finished line stays finished until the next line start
    done_held: assert property (@(posedge clk) disable iff (rst)
        done && !line_start |=> done)
        else $error("done fell outside a line start");

    no_pixel_when_done: assert property (@(posedge clk) disable iff (rst)
        lut_valid |-> !done)
        else $error("lut_valid while done is high");

endmodule

bind obj_drawer obj_gfx_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .line_start (line_start),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .rom_addr   (rom_addr),
    .lut_valid  (lut_valid),
    .done       (done)
);

`default_nettype wire

// File: sim/obj_gfx_tb.sv
// object layer testbench
`default_nettype none

module obj_gfx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    logic        obj_we;
    logic [8:0]  obj_addr;
    logic [7:0]  obj_din;
    logic        lut_we;
    logic [7:0]  lut_addr;
    logic [3:0]  lut_din;
    logic        rom_cs;
    logic [17:0] rom_addr;
    logic        rom_ok;
    logic [15:0] rom_data;
    logic [3:0]  pxl;
    logic        done;

    logic [7:0]  tbl [0:319];        // mirror of the attribute RAM
    logic [3:0]  lut_m [0:255];      // mirror of the LUT
    logic [3:0]  exp_next [0:511];
    logic [3:0]  exp_cur [0:511];
    logic        next_ok;
    logic        cur_ok;
    logic        running;
    logic        run_q;
    logic [8:0]  hd_q;
    logic [31:0] rand_state;

    obj_gfx_top #(.LUT_DW(4), .LINE_AW(9)) u_obj_gfx_top (
        .clk (clk), .rst (rst), .pxl_cen (pxl_cen), .LHBL (lhbl), .LVBL (lvbl),
        .vrender (vrender), .hdump (hdump),
        .obj_we (obj_we), .obj_addr (obj_addr), .obj_din (obj_din),
        .lut_we (lut_we), .lut_addr (lut_addr), .lut_din (lut_din),
        .rom_cs (rom_cs), .rom_addr (rom_addr), .rom_ok (rom_ok), .rom_data (rom_data),
        .pxl (pxl), .done (done)
    );

    obj_rom_model u_rom (
        .clk (clk), .rst (rst), .rom_cs (rom_cs), .rom_addr (rom_addr),
        .rom_ok (rom_ok), .rom_data (rom_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] rom_pattern(input logic [17:0] addr);
        logic [31:0] m;
        m = {14'd0, addr} * 32'h9e37_79b1;
        return m[31:16] ^ addr[15:0];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] expv,
                             input string what);
        if (got !== expv) begin
            $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, expv);
            fail_run("pixel check failed");
        end
    endtask

    // expected line from the table and LUT mirrors
    function automatic void ref_line(input int v);
        int          cnt;
        int          b;
        int          h;
        int          nw;
        int          wi;
        int          pos;
        logic [7:0]  sz;
        logic [7:0]  y;
        logic [8:0]  vd;
        logic [8:0]  x;
        logic [3:0]  row;
        logic [3:0]  nib;
        logic [3:0]  pal;
        logic [3:0]  colr;
        logic [13:0] code;
        logic [17:0] addr;
        logic [15:0] word;
        cnt = 0;
        for (int i = 0; i < 512; i++) begin
            exp_next[i] = 4'd0;
        end
        for (int e = 0; e < 64; e++) begin
            b  = e * 5;
            sz = tbl[b + 4];
            y  = tbl[b + 2];
            if (y == 8'd240) break;         // end of list
            h  = sz[1] ? 16 : 8;
            nw = sz[1] ? 4 : 2;
            vd = 9'(v) - {1'b0, y};
            if (vd < 9'(h)) begin
                row  = vd[3:0] ^ {4{sz[5]}};
                pal  = tbl[b + 1][7:4];
                code = {sz[7:6], tbl[b + 1][1:0], tbl[b], tbl[b + 1][3:2]};
                x    = {sz[0], tbl[b + 3]};
                for (int c = 0; c < h; c++) begin
                    wi = sz[4] ? nw - 1 - c / 4 : c / 4;
                    if (sz[1]) begin
                        addr = {code[13:2], row[3], wi[1], row[2:0], wi[0]};
                    end else begin
                        addr = {code, row[2:0], wi[0]};
                    end
                    word = rom_pattern(addr);
                    nib  = sz[4] ? word[4 * (c % 4) +: 4] : word[15 - 4 * (c % 4) -: 4];
                    colr = lut_m[{pal, nib}];
                    pos  = (x + c) % 512;
                    if (colr != 4'd0 && exp_next[pos] == 4'd0) begin
                        exp_next[pos] = colr;   // earliest entry keeps the pixel
                    end
                end
                cnt += h;
            end
            if (cnt >= 384) break;          // pixel budget
        end
    endfunction

    // new expectation lines up with the bank swap
    always @(posedge clk) begin
        if (hdump == 9'd0 && lhbl && running) begin
            for (int i = 0; i < 512; i++) begin
                exp_cur[i] <= exp_next[i];
            end
            cur_ok <= next_ok;
        end
        hd_q  <= hdump;
        run_q <= running;
    end

    always @(negedge clk) begin
        if (run_q && cur_ok) begin
            check_val(pxl, exp_cur[hd_q], $sformatf("pxl at hdump %0d", hd_q));
        end
    end

    task automatic obj_write(input int a, input logic [7:0] d);
        @(negedge clk);
        obj_we   = 1'b1;
        obj_addr = 9'(a);
        obj_din  = d;
        tbl[a]   = d;
        @(negedge clk);
        obj_we = 1'b0;
    endtask

    task automatic lut_write(input int a, input logic [3:0] d);
        @(negedge clk);
        lut_we   = 1'b1;
        lut_addr = 8'(a);
        lut_din  = d;
        lut_m[a] = d;
        @(negedge clk);
        lut_we = 1'b0;
    endtask

    task automatic write_obj(input int idx, input logic [7:0] code, input logic [7:0] colb,
                             input logic [7:0] y, input logic [8:0] x, input logic [7:0] flags);
        obj_write(idx * 5 + 0, code);
        obj_write(idx * 5 + 1, colb);
        obj_write(idx * 5 + 2, y);
        obj_write(idx * 5 + 3, x[7:0]);
        obj_write(idx * 5 + 4, flags | {7'd0, x[8]});
    endtask

    task automatic clear_objs();
        for (int i = 0; i < 64; i++) begin
            write_obj(i, 8'h00, 8'h00, 8'd250, 9'd0, 8'h00);  // off every line
        end
    endtask

    task automatic load_lut_default();
        logic [7:0] i8;
        for (int i = 0; i < 256; i++) begin
            i8 = 8'(i);
            // palette 3 also hides even pixels
            if (i8[3:0] == 4'd0 || (i8[7:4] == 4'd3 && !i8[0])) begin
                lut_write(i, 4'd0);
            end else begin
                lut_write(i, i8[3:0] ^ i8[7:4]);
            end
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 5000) fail_run("timed out waiting for the drawer to finish a line");
        end
    endtask

    // one video line, stretched in blanking until the drawer is done
    task automatic run_line(input int v);
        for (int h = 0; h < 512; h++) begin
            @(negedge clk);
            hdump   = 9'(h);
            lhbl    = h < 384;
            running = 1'b1;
            if (h == 0) vrender = 9'(v);
            if (h == 1) begin
                ref_line(v);
                next_ok = 1'b1;
            end
        end
        @(negedge clk);
        running = 1'b0;
        wait_done();
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b1;
        lhbl = 1'b0;
        lvbl = 1'b1;
        vrender = 9'd0;
        hdump = 9'd0;
        obj_we = 1'b0;
        obj_addr = 9'd0;
        obj_din = 8'd0;
        lut_we = 1'b0;
        lut_addr = 8'd0;
        lut_din = 4'd0;
        next_ok = 1'b0;
        cur_ok = 1'b0;
        running = 1'b0;
        rand_state = 32'h3131_a98d;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        clear_objs();
        load_lut_default();

        write_obj(0, 8'h12, 8'h20, 8'd50, 9'd100, 8'h00);      // plain 8x8
        for (int v = 44; v < 62; v++) run_line(v);

        clear_objs();
        for (int k = 0; k < 4; k++) begin
            write_obj(k, 8'h40 + 8'(k * 8), 8'h51, 8'd80, 9'(20 + k * 40),
                      {2'b01, k[1], k[0], 4'b0010});
        end
        for (int v = 76; v < 99; v++) run_line(v);

        clear_objs();
        write_obj(0, 8'h21, 8'h30, 8'd120, 9'd200, 8'h00);     // front, with holes
        write_obj(1, 8'h66, 8'h52, 8'd116, 9'd196, 8'h02);
        for (int v = 114; v < 135; v++) run_line(v);

        clear_objs();
        write_obj(0, 8'h33, 8'h71, 8'd150, 9'd40, 8'h00);
        write_obj(1, 8'h00, 8'h00, 8'd240, 9'd0, 8'h00);       // end marker
        write_obj(2, 8'h34, 8'h81, 8'd150, 9'd80, 8'h00);
        for (int v = 148; v < 160; v++) run_line(v);

        clear_objs();
        for (int i = 0; i < 26; i++) begin
            write_obj(i, 8'(i * 4 + 1), {4'(i), 4'h0}, 8'd180, 9'(i * 16), 8'h02);
        end
        for (int v = 180; v < 183; v++) run_line(v);

        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 256; i++) begin
                rand_state = lcg_next(rand_state);
                lut_write(i, rand_state[19:16]);
            end
            for (int e = 0; e < 16; e++) begin
                rand_state = lcg_next(rand_state);
                write_obj(e, rand_state[31:24], rand_state[23:16],
                          8'(rand_state[15:8] % 240), {rand_state[7], rand_state[31:24]},
                          rand_state[15:8] & 8'hfe);
            end
            write_obj(16, 8'h00, 8'h00, 8'd240, 9'd0, 8'h00);
            for (int n = 0; n < 24; n++) begin
                rand_state = lcg_next(rand_state);
                run_line(int'(rand_state[23:16]));
            end
        end
        run_line(0);                        // plays out the last render

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/obj_rom_model.sv
// tile ROM model
`default_nettype none

module obj_rom_model #(
    parameter logic [31:0] SEED = 32'h3131_a98d
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rom_cs,
    input  logic [obj_pkg::OBJ_ROM_AW-1:0]  rom_addr,
    output logic                            rom_ok,
    output logic [15:0]                     rom_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] state;
    logic [31:0] state_nxt;
    logic        pending;
    logic [2:0]  wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // data depends on every address bit
    function automatic logic [15:0] tile_word(input logic [17:0] addr);
        logic [31:0] m;
        m = {14'd0, addr} * 32'h9e37_79b1;
        return m[31:16] ^ addr[15:0];
    endfunction

    assign state_nxt = lcg_next(state);

    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= 3'd0;
            state    <= SEED;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok) begin
                if (!pending) begin
                    state    <= state_nxt;
                    wait_cnt <= 3'(state_nxt[18:16] % 6);  // random wait length
                    pending  <= 1'b1;
                end else if (wait_cnt == 3'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= tile_word(rom_addr);
                    pending  <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/obj_attr_ram.sv
// object attribute RAM
`default_nettype none

module obj_attr_ram (
    input  logic                              clk,
    input  logic                              obj_we,
    input  logic [obj_pkg::OBJ_TABLE_AW-1:0]  obj_addr,
    input  logic [7:0]                        obj_din,
    input  logic [obj_pkg::OBJ_TABLE_AW-1:0]  scan_addr,
    output logic [7:0]                        obj_scan
);
    import obj_pkg::*;

    logic [7:0] mem [0:OBJ_TABLE_SIZE-1];
    logic       addr_ok;

    // writes past the table are dropped
    assign addr_ok = obj_addr < OBJ_TABLE_AW'(OBJ_TABLE_SIZE);

    always_ff @(posedge clk) begin
        if (obj_we && addr_ok) begin
            mem[obj_addr] <= obj_din;
        end
    end

    // drawer side, one cycle of latency
    always_ff @(posedge clk) begin
        obj_scan <= mem[scan_addr];
    end

endmodule

`default_nettype wire

// File: source/obj_color_lut.sv
// object colour lookup table
`default_nettype none

module obj_color_lut #(
    parameter int LUT_DW = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              lut_we,
    input  logic [7:0]        lut_addr,
    input  logic [LUT_DW-1:0] lut_din,
    input  logic [7:0]        lut_index,
    input  logic              lut_valid,
    input  logic [8:0]        xpos,
    output logic [LUT_DW-1:0] wr_data,
    output logic [8:0]        wr_addr,
    output logic              we
);

    logic [LUT_DW-1:0] lut [0:255];

    always_ff @(posedge clk) begin
        if (lut_we) begin
            lut[lut_addr] <= lut_din;
        end
    end

    // index is palette in the upper nibble, pixel in the lower
    always_ff @(posedge clk) begin
        wr_data <= lut[lut_index];
        wr_addr <= xpos;            // keep position with its colour
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            we <= 1'b0;
        end else begin
            we <= lut_valid;
        end
    end

endmodule

`default_nettype wire

// File: source/obj_gfx_top.sv
// object layer top level
`default_nettype none

module obj_gfx_top #(
    parameter int LUT_DW  = 4,
    parameter int LINE_AW = 9
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pxl_cen,
    input  logic                              LHBL,
    input  logic                              LVBL,
    input  logic [8:0]                        vrender,
    input  logic [8:0]                        hdump,
    // cpu side
    input  logic                              obj_we,
    input  logic [obj_pkg::OBJ_TABLE_AW-1:0]  obj_addr,
    input  logic [7:0]                        obj_din,
    input  logic                              lut_we,
    input  logic [7:0]                        lut_addr,
    input  logic [LUT_DW-1:0]                 lut_din,
    // tile rom
    output logic                              rom_cs,
    output logic [obj_pkg::OBJ_ROM_AW-1:0]    rom_addr,
    input  logic                              rom_ok,
    input  logic [15:0]                       rom_data,
    output logic [LUT_DW-1:0]                 pxl,
    output logic                              done
);

    logic [obj_pkg::OBJ_TABLE_AW-1:0] scan_addr;
    logic [7:0]                       obj_scan;
    logic [7:0]                       lut_index;
    logic                             lut_valid;
    logic [8:0]                       xpos;
    logic [LUT_DW-1:0]                line_data;
    logic [8:0]                       line_addr;
    logic                             line_we;

    obj_attr_ram u_attr_ram (
        .clk       (clk),
        .obj_we    (obj_we),
        .obj_addr  (obj_addr),
        .obj_din   (obj_din),
        .scan_addr (scan_addr),
        .obj_scan  (obj_scan)
    );

    obj_drawer u_drawer (
        .clk       (clk),
        .rst       (rst),
        .LHBL      (LHBL),
        .LVBL      (LVBL),
        .vrender   (vrender),
        .scan_addr (scan_addr),
        .obj_scan  (obj_scan),
        .lut_index (lut_index),
        .lut_valid (lut_valid),
        .xpos      (xpos),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .done      (done)
    );

    obj_color_lut #(
        .LUT_DW (LUT_DW)
    ) u_color_lut (
        .clk       (clk),
        .rst       (rst),
        .lut_we    (lut_we),
        .lut_addr  (lut_addr),
        .lut_din   (lut_din),
        .lut_index (lut_index),
        .lut_valid (lut_valid),
        .xpos      (xpos),
        .wr_data   (line_data),
        .wr_addr   (line_addr),
        .we        (line_we)
    );

    obj_line_buffer #(
        .LUT_DW  (LUT_DW),
        .LINE_AW (LINE_AW)
    ) u_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .we      (line_we),
        .wr_addr (line_addr[LINE_AW-1:0]),
        .wr_data (line_data),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire
